// ==== flist.f ====
+incdir+design
design/vid_pkg.sv
design/vid_regs.sv
design/vid_timing.sv
design/vid_fetch.sv
design/vid_fifo.sv
design/vid_pixel_out.sv
design/vid_top.sv
testbench/vid_tb.sv

// ==== testbench/vid_tb.sv ====
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_tb import vid_pkg::*; ();

    localparam int PERIOD     = 100;
    localparam int NUM_CFG    = 3;
    localparam int SETUP_CLKS = 200;  // Register writes, sync and idle checks per run

    typedef struct packed {
        logic [`VID_PCNT_W-1:0] pcnt;
        hv_regs_t               hv;
        logic [31:0]            base;
        logic [31:0]            inc;
    } vid_cfg_t;

    logic        clk;
    logic        reset_n;
    bus_cmd_t    cmd_in;
    logic [31:0] addr_data_in;
    logic        write_resp;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic [1:0]  mem_len;
    logic        mem_rdata_valid;
    logic [31:0] mem_rdata;
    logic        hsync;
    logic        hblank;
    logic        vsync;
    logic        vblank;
    rgb_t        rgb;
    logic        pixel_valid;
    logic        underrun;

    vid_cfg_t    cfgs [NUM_CFG];
    vid_cfg_t    cur;               // Configuration of the current run
    logic [31:0] cfg_seed;
    logic [31:0] mem_seed;
    logic        sync_wait;         // Waiting for the first displayed pixel slot
    logic        running;
    logic        run_done;
    int          k;                 // Clocks since the run was aligned
    int          frame_clks;
    int          req_line;          // Next expected fetch position
    int          req_word;
    logic        outstanding;
    logic        last_sent;
    logic [31:0] burst_addr;
    int          beat;
    int          gap;
    longint      limit_clks;
    logic        limit_ready;

    vid_top i_dut (.*);

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int pick(input int n);
        cfg_seed = lcg_next(cfg_seed);
        return int'(cfg_seed >> 16) % n;
    endfunction

    function automatic int pick_gap();
        mem_seed = lcg_next(mem_seed);
        return int'(mem_seed >> 16) % 4;   // 0 to 3 idle clocks
    endfunction

    // Memory content, fixed per address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] x;
        x = addr * 32'h9e37_79b1;
        x = x ^ (x >> 15);
        return x;
    endfunction

    function automatic vid_cfg_t make_cfg();
        vid_cfg_t c;
        int hs;
        int he;
        int vs;
        int ve;
        int vss;
        c = '0;
        c.pcnt = `VID_PCNT_W'(pick(3));
        hs = 8 + 4 * pick(3);
        he = 4 * hs - 1 + pick(8);      // Long blanking keeps the fetch ahead
        c.hv.hsize       = `VID_CNT_W'(hs);
        c.hv.hend        = `VID_CNT_W'(he);
        c.hv.hsync_start = `VID_CNT_W'(hs + 1 + pick(4));
        c.hv.hsync_end   = c.hv.hsync_start + `VID_CNT_W'(1 + pick(8));
        vs  = 2 + pick(3);
        ve  = vs + 2 + pick(3);
        vss = vs + 1;
        c.hv.vsize       = `VID_CNT_W'(vs);
        c.hv.vend        = `VID_CNT_W'(ve);
        c.hv.vsync_start = `VID_CNT_W'(vss);
        c.hv.vsync_end   = `VID_CNT_W'(vss + 1 + pick(ve - vss + 1));
        c.base = lcg_next(cfg_seed) & 32'h00ff_fff0;
        c.inc  = 32'((hs + pick(16)) * 4);
        return c;
    endfunction

    function automatic int frame_len(input vid_cfg_t c);
        return (int'(c.hv.vend) + 1) * (int'(c.hv.hend) + 1) * (int'(c.pcnt) + 1);
    endfunction

    // Reference position of the raster at a clock of the run
    function automatic int pos_h(input int kk);
        return (kk / (int'(cur.pcnt) + 1)) % (int'(cur.hv.hend) + 1);
    endfunction

    function automatic int pos_v(input int kk);
        int line;
        line = kk / ((int'(cur.pcnt) + 1) * (int'(cur.hv.hend) + 1));
        return (int'(cur.hv.vsize) + line) % (int'(cur.hv.vend) + 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic host_write(input logic [31:0] ofs, input logic [31:0] value);
        @(negedge clk);
        cmd_in       = cmd_write_req;
        addr_data_in = ofs;
        @(negedge clk);
        check_value("write_resp", 32'd0, write_resp);
        cmd_in       = cmd_write_data;
        addr_data_in = value;
        @(negedge clk);
        check_value("write_resp", 32'd1, write_resp);   // One clock after the data cycle
        cmd_in       = cmd_idle;
        addr_data_in = '0;
        @(negedge clk);
        check_value("write_resp", 32'd0, write_resp);
    endtask

    task automatic check_idle(input int clocks);
        repeat (clocks) begin
            @(negedge clk);
            check_value("hsync", 32'd0, hsync);
            check_value("vsync", 32'd0, vsync);
            check_value("hblank", 32'd1, hblank);
            check_value("vblank", 32'd1, vblank);
            check_value("mem_req", 32'd0, mem_req);
            check_value("pixel_valid", 32'd0, pixel_valid);
            check_value("rgb", 32'd0, rgb);
            check_value("underrun", 32'd0, underrun);
        end
    endtask

    task automatic program_cfg(input vid_cfg_t c);
        host_write(`VID_OFS_H1, {6'd0, c.hv.hsize, c.hv.hend});
        host_write(`VID_OFS_H2, {6'd0, c.hv.hsync_start, c.hv.hsync_end});
        host_write(`VID_OFS_V1, {6'd0, c.hv.vsize, c.hv.vend});
        host_write(`VID_OFS_V2, {6'd0, c.hv.vsync_start, c.hv.vsync_end});
        host_write(`VID_OFS_BASE, c.base);
        host_write(`VID_OFS_LINEINC, c.inc);
        host_write(32'h0000_0010, 32'hffff_ffff);      // Unmapped offset
    endtask

    initial begin
        int i;
        clk             = 1'b0;
        reset_n         = 1'b0;
        cmd_in          = cmd_idle;
        addr_data_in    = '0;
        mem_rdata_valid = 1'b0;
        mem_rdata       = '0;
        cfg_seed        = 32'h7fca;
        mem_seed        = 32'h7fca;
        cur             = '0;
        sync_wait       = 1'b0;
        running         = 1'b0;
        run_done        = 1'b0;
        k               = 0;
        frame_clks      = 0;
        req_line        = 0;
        req_word        = 0;
        outstanding     = 1'b0;
        last_sent       = 1'b0;
        burst_addr      = '0;
        beat            = 0;
        gap             = 0;
        limit_clks      = SETUP_CLKS;
        for (i = 0; i < NUM_CFG; i++) begin
            cfgs[i]    = make_cfg();
            limit_clks = limit_clks + 4 * frame_len(cfgs[i]) + SETUP_CLKS;
        end
        limit_ready = 1'b1;

        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        check_idle(10);

        for (i = 0; i < NUM_CFG; i++) begin
            program_cfg(cfgs[i]);
            cur        = cfgs[i];
            frame_clks = frame_len(cfgs[i]);
            req_line   = 0;
            req_word   = 0;
            k          = 0;
            run_done   = 1'b0;
            sync_wait  = 1'b1;
            host_write(`VID_OFS_CTRL, {22'd0, cfgs[i].pcnt, 1'b1, 3'b000});
            wait (k > 100);
            host_write(`VID_OFS_H1, {6'd0, 13'd4, 13'd5});  // Locked while enabled
            host_write(`VID_OFS_BASE, 32'h1234_5670);
            wait (run_done);
            host_write(`VID_OFS_CTRL, {22'd0, cfgs[i].pcnt, 1'b0, 3'b000});
            repeat (3) @(negedge clk);
            check_idle(5);
        end
        $display("Simulation passed");
        $finish;
    end

    // Timing and pixel reference, aligned on the first hblank fall of a run
    always @(negedge clk) begin
        int h;
        int v;
        int hp;
        int vp;
        int kp;
        logic [31:0] w;
        if (sync_wait && !hblank) begin
            sync_wait = 1'b0;
            running   = 1'b1;
            k         = 0;
        end
        if (running) begin
            h = pos_h(k);
            v = pos_v(k);
            check_value("hblank", 32'(h >= cur.hv.hsize), hblank);
            check_value("hsync", 32'(h >= cur.hv.hsync_start && h < cur.hv.hsync_end), hsync);
            check_value("vblank", 32'(v >= cur.hv.vsize), vblank);
            check_value("vsync", 32'(v >= cur.hv.vsync_start && v < cur.hv.vsync_end), vsync);
            if (k == 0) begin
                check_value("pixel_valid", 32'd0, pixel_valid);
            end else begin
                kp = k - 1;
                hp = pos_h(kp);
                vp = pos_v(kp);
                if ((kp % (int'(cur.pcnt) + 1) == 0) && hp < cur.hv.hsize
                        && vp < cur.hv.vsize) begin
                    w = mem_word(cur.base + 32'(vp) * cur.inc + 32'(4 * hp));
                    check_value("pixel_valid", 32'd1, pixel_valid);
                    check_value("rgb", {8'd0, w[23:0]}, rgb);
                end else begin
                    check_value("pixel_valid", 32'd0, pixel_valid);
                    if (hp >= cur.hv.hsize || vp >= cur.hv.vsize) begin
                        check_value("rgb", 32'd0, rgb);  // Black outside display
                    end
                end
            end
            check_value("underrun", 32'd0, underrun);
            k = k + 1;
            if (k == 2 * frame_clks) begin
                running  = 1'b0;
                run_done = 1'b1;
            end
        end
    end

    // Memory model with random gaps between strobes
    always @(negedge clk) begin
        logic [31:0] exp_addr;
        if (reset_n) begin
            if (mem_req) begin
                check_value("mem_len", `VID_LEN_CODE, mem_len);
                check_value("burst outstanding at mem_req", 32'd0, outstanding);
                exp_addr = cur.base + 32'(req_line) * cur.inc + 32'(4 * req_word);
                check_value("mem_addr", exp_addr, mem_addr);
                req_word = req_word + `VID_BURST_LEN;
                if (req_word == cur.hv.hsize) begin
                    req_word = 0;
                    req_line = (req_line + 1 == cur.hv.vsize) ? 0 : req_line + 1;
                end
                outstanding = 1'b1;
                burst_addr  = mem_addr;
                beat        = 0;
                gap         = pick_gap();
            end
            if (last_sent) begin            // Fourth strobe was taken at the last edge
                outstanding = 1'b0;
                last_sent   = 1'b0;
            end
            if (outstanding && !last_sent && gap == 0) begin
                mem_rdata_valid = 1'b1;
                mem_rdata       = mem_word(burst_addr + 32'(4 * beat));
                beat            = beat + 1;
                if (beat == `VID_BURST_LEN) begin
                    last_sent = 1'b1;
                end else begin
                    gap = pick_gap();
                end
            end else begin
                mem_rdata_valid = 1'b0;
                if (outstanding && gap > 0) begin
                    gap = gap - 1;
                end
            end
        end
    end

    initial begin
        wait (limit_ready);
        #(limit_clks * PERIOD);
        $display("Timeout: the test did not finish within %0d clocks", limit_clks);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== design/vid_top.sv ====
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_top import vid_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_n,
    input  bus_cmd_t               cmd_in,
    input  logic [`VID_ADDR_W-1:0] addr_data_in,
    output logic                   write_resp,
    output logic                   mem_req,
    output logic [`VID_ADDR_W-1:0] mem_addr,
    output logic [1:0]             mem_len,
    input  logic                   mem_rdata_valid,
    input  logic [`VID_ADDR_W-1:0] mem_rdata,
    output logic                   hsync,
    output logic                   hblank,
    output logic                   vsync,
    output logic                   vblank,
    output rgb_t                   rgb,
    output logic                   pixel_valid,
    output logic                   underrun
);

    ctrl_reg_t                  ctrl;
    hv_regs_t                   hv;
    logic [`VID_ADDR_W-1:0]     base_addr;
    logic [`VID_ADDR_W-1:0]     line_inc;
    timing_t                    tm;
    logic [`VID_FIFO_CNT_W-1:0] fifo_free;
    logic                       fifo_empty;
    logic                       push;
    logic                       pop;
    logic                       flush;
    rgb_t                       push_data;
    rgb_t                       pop_data;

    assign hsync  = tm.hsync;
    assign hblank = tm.hblank;
    assign vsync  = tm.vsync;
    assign vblank = tm.vblank;

    vid_regs i_regs (
        .clk, .reset_n, .cmd_in, .addr_data_in, .write_resp,
        .ctrl, .hv, .base_addr, .line_inc
    );

    vid_timing i_timing (
        .clk, .reset_n, .ctrl, .hv, .tm
    );

    vid_fetch i_fetch (
        .clk, .reset_n, .en(ctrl.en), .tm, .hsize(hv.hsize), .vsize(hv.vsize),
        .base_addr, .line_inc, .fifo_free, .mem_req, .mem_addr, .mem_len,
        .mem_rdata_valid, .mem_rdata, .push, .push_data, .flush
    );

    vid_fifo i_fifo (
        .clk, .reset_n, .flush, .push, .push_data, .pop, .pop_data,
        .empty(fifo_empty), .free(fifo_free)
    );

    vid_pixel_out i_pixel_out (
        .clk, .reset_n, .tm, .empty(fifo_empty), .pop, .pop_data,
        .rgb, .pixel_valid, .underrun
    );

endmodule

// ==== design/vid_pixel_out.sv ====
`timescale 1ns/1ps

module vid_pixel_out import vid_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  timing_t tm,
    input  logic    empty,
    output logic    pop,
    input  rgb_t    pop_data,
    output rgb_t    rgb,
    output logic    pixel_valid,
    output logic    underrun
);

    logic show;     // Pixel slot in active display

    assign show = tm.tick && !tm.hblank && !tm.vblank;
    assign pop  = show && !empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rgb         <= '0;
            pixel_valid <= 1'b0;
            underrun    <= 1'b0;
        end else begin
            pixel_valid <= show;
            if (show) begin
                rgb <= empty ? '0 : pop_data;
                if (empty) begin
                    underrun <= 1'b1;   // Sticky until reset
                end
            end else if (tm.hblank || tm.vblank) begin
                rgb <= '0;
            end
        end
    end

endmodule

// ==== design/vid_fifo.sv ====
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_fifo import vid_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       flush,
    input  logic                       push,
    input  rgb_t                       push_data,
    input  logic                       pop,
    output rgb_t                       pop_data,
    output logic                       empty,
    output logic [`VID_FIFO_CNT_W-1:0] free
);

    localparam int PTR_W = $clog2(`VID_FIFO_DEPTH);
    localparam logic [`VID_FIFO_CNT_W-1:0] DEPTH = `VID_FIFO_CNT_W'(`VID_FIFO_DEPTH);

    rgb_t                       mem [`VID_FIFO_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [`VID_FIFO_CNT_W-1:0] count;

    assign empty    = (count == '0);
    assign free     = DEPTH - count;
    assign pop_data = mem[rd_ptr];      // Show-ahead read

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin       // Wins over push and pop
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Fetch back-pressure must keep the FIFO from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        (push && !flush) |-> (count != DEPTH));

    a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
        (pop && !flush) |-> !empty);

endmodule

// ==== design/vid_fetch.sv ====
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_fetch import vid_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       en,
    input  timing_t                    tm,
    input  logic [`VID_CNT_W-1:0]      hsize,
    input  logic [`VID_CNT_W-1:0]      vsize,
    input  logic [`VID_ADDR_W-1:0]     base_addr,
    input  logic [`VID_ADDR_W-1:0]     line_inc,
    input  logic [`VID_FIFO_CNT_W-1:0] fifo_free,
    output logic                       mem_req,
    output logic [`VID_ADDR_W-1:0]     mem_addr,
    output logic [1:0]                 mem_len,
    input  logic                       mem_rdata_valid,
    input  logic [`VID_ADDR_W-1:0]     mem_rdata,
    output logic                       push,
    output rgb_t                       push_data,
    output logic                       flush
);

    localparam logic [`VID_CNT_W-1:0]      BURST_WORDS = `VID_CNT_W'(`VID_BURST_LEN);
    localparam logic [`VID_FIFO_CNT_W-1:0] BURST_ROOM  = `VID_FIFO_CNT_W'(`VID_BURST_LEN);
    localparam logic [1:0]                 LAST_BEAT   = 2'(`VID_BURST_LEN - 1);

    logic                   active;     // Frame still has lines to fetch
    logic                   busy;       // Burst outstanding
    logic                   stale;      // Outstanding burst belongs to the old frame
    logic [`VID_ADDR_W-1:0] line_base;
    logic [`VID_CNT_W-1:0]  word_idx;
    logic [`VID_CNT_W-1:0]  line_num;
    logic [1:0]             rcv_cnt;
    logic                   issue;
    logic                   last_word;
    logic                   last_beat;

    assign flush     = tm.frame_start;
    assign mem_len   = `VID_LEN_CODE;
    assign issue     = en && active && !busy && !tm.frame_start && (fifo_free >= BURST_ROOM);
    assign last_word = ((word_idx + BURST_WORDS) == hsize);
    assign last_beat = mem_rdata_valid && busy && (rcv_cnt == LAST_BEAT);
    assign push      = mem_rdata_valid && busy && !stale;
    assign push_data = rgb_t'(mem_rdata[23:0]);   // R in 23:16, G in 15:8, B in 7:0

    always_ff @(posedge clk) begin
        if (issue) begin
            mem_addr <= line_base + `VID_ADDR_W'({word_idx, 2'b00});
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_req   <= 1'b0;
            active    <= 1'b0;
            busy      <= 1'b0;
            stale     <= 1'b0;
            rcv_cnt   <= '0;
            line_base <= '0;
            word_idx  <= '0;
            line_num  <= '0;
        end else begin
            mem_req <= issue;
            if (mem_rdata_valid && busy) begin
                rcv_cnt <= rcv_cnt + 1'b1;
            end
            if (last_beat) begin
                busy  <= 1'b0;
                stale <= 1'b0;
            end
            if (issue) begin
                busy <= 1'b1;
            end
            if (tm.frame_start) begin       // Restart at line 0 word 0
                active    <= en;
                line_base <= base_addr;
                word_idx  <= '0;
                line_num  <= '0;
                if (busy && !last_beat) begin
                    stale <= 1'b1;
                end
            end else if (!en) begin
                active <= 1'b0;
            end else if (issue) begin
                if (last_word) begin
                    word_idx  <= '0;
                    line_num  <= line_num + 1'b1;
                    line_base <= line_base + line_inc;
                    if ((line_num + 1'b1) == vsize) begin
                        active <= 1'b0;     // Wait for the next frame
                    end
                end else begin
                    word_idx <= word_idx + BURST_WORDS;
                end
            end
        end
    end

    // A new request starts a fresh burst with no beats of an earlier one pending
    a_one_outstanding: assert property (@(posedge clk) disable iff (!reset_n)
        mem_req |-> (busy && (rcv_cnt == '0)));

    // Memory only returns data against a pending request
    a_no_orphan_data: assert property (@(posedge clk) disable iff (!reset_n)
        mem_rdata_valid |-> busy);

endmodule

// ==== design/vid_timing.sv ====
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_timing import vid_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  ctrl_reg_t ctrl,
    input  hv_regs_t  hv,
    output timing_t   tm
);

    logic [`VID_PCNT_W-1:0] pdiv;
    logic [`VID_CNT_W-1:0]  h;
    logic [`VID_CNT_W-1:0]  v;
    logic [`VID_CNT_W-1:0]  h_new;
    logic [`VID_CNT_W-1:0]  v_new;
    logic                   en_q;
    logic                   adv;
    logic                   h_wrap;

    assign adv    = ctrl.en && en_q && (pdiv == ctrl.pcnt);
    assign h_wrap = (h == hv.hend);

    // Position after this clock
    always_comb begin
        h_new = h;
        v_new = v;
        if (!en_q) begin                    // Start of a run opens in vblank
            h_new = '0;
            v_new = hv.vsize;
        end else if (adv) begin
            h_new = h_wrap ? '0 : h + 1'b1;
            if (h_wrap) begin
                v_new = (v == hv.vend) ? '0 : v + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en_q           <= 1'b0;
            pdiv           <= '0;
            h              <= '0;
            v              <= '0;
            tm.hsync       <= 1'b0;
            tm.hblank      <= 1'b1;
            tm.vsync       <= 1'b0;
            tm.vblank      <= 1'b1;
            tm.tick        <= 1'b0;
            tm.frame_start <= 1'b0;
        end else begin
            en_q    <= ctrl.en;
            tm.tick <= adv;
            if (!ctrl.en) begin             // Idle levels
                pdiv           <= '0;
                tm.hsync       <= 1'b0;
                tm.hblank      <= 1'b1;
                tm.vsync       <= 1'b0;
                tm.vblank      <= 1'b1;
                tm.frame_start <= 1'b0;
            end else begin
                pdiv      <= (adv || !en_q) ? '0 : pdiv + 1'b1;
                h         <= h_new;
                v         <= v_new;
                tm.hblank <= (h_new >= hv.hsize);
                tm.hsync  <= (h_new >= hv.hsync_start) && (h_new < hv.hsync_end);
                tm.vblank <= (v_new >= hv.vsize);
                tm.vsync  <= (v_new >= hv.vsync_start) && (v_new < hv.vsync_end);
                // Entering vertical blank, also at the start of a run
                tm.frame_start <= !en_q || (adv && h_wrap && (v_new == hv.vsize));
            end
        end
    end

    a_tick_gap: assert property (@(posedge clk) disable iff (!reset_n)
        (tm.tick && (ctrl.pcnt != '0)) |=> !tm.tick);

endmodule

// ==== design/vid_regs.sv ====
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_regs import vid_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_n,
    input  bus_cmd_t               cmd_in,
    input  logic [`VID_ADDR_W-1:0] addr_data_in,
    output logic                   write_resp,
    output ctrl_reg_t              ctrl,
    output hv_regs_t               hv,
    output logic [`VID_ADDR_W-1:0] base_addr,
    output logic [`VID_ADDR_W-1:0] line_inc
);

    logic                   pend;       // Offset latched, data phase expected
    logic [`VID_ADDR_W-1:0] ofs_q;
    logic                   wr_data;

    assign wr_data = pend && (cmd_in == cmd_write_data);

    always_ff @(posedge clk) begin
        if (cmd_in == cmd_write_req) begin
            ofs_q <= addr_data_in;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pend       <= 1'b0;
            write_resp <= 1'b0;
            ctrl       <= '0;
            hv         <= '0;
            base_addr  <= '0;
            line_inc   <= '0;
        end else begin
            pend       <= (cmd_in == cmd_write_req);
            write_resp <= wr_data;              // Ack every data phase
            if (wr_data) begin
                if (ofs_q == `VID_OFS_CTRL) begin
                    ctrl.en   <= addr_data_in[3];
                    ctrl.pcnt <= addr_data_in[9:4];
                end else if (!ctrl.en) begin    // Timing and fetch regs locked while running
                    case (ofs_q)
                        `VID_OFS_H1: begin
                            hv.hend  <= addr_data_in[12:0];
                            hv.hsize <= addr_data_in[25:13];
                        end
                        `VID_OFS_H2: begin
                            hv.hsync_start <= addr_data_in[25:13];
                            hv.hsync_end   <= addr_data_in[12:0];
                        end
                        `VID_OFS_V1: begin
                            hv.vend  <= addr_data_in[12:0];
                            hv.vsize <= addr_data_in[25:13];
                        end
                        `VID_OFS_V2: begin
                            hv.vsync_start <= addr_data_in[25:13];
                            hv.vsync_end   <= addr_data_in[12:0];
                        end
                        `VID_OFS_BASE:    base_addr <= addr_data_in;
                        `VID_OFS_LINEINC: line_inc  <= addr_data_in;
                        default: ;                  // Unknown offset, ack only
                    endcase
                end
            end
        end
    end

    // One response per write, back-to-back writes need two bus cycles each
    a_resp_single: assert property (@(posedge clk) disable iff (!reset_n)
        write_resp |=> !write_resp);

endmodule

// ==== design/vid_pkg.sv ====
`include "vid_config.svh"

package vid_pkg;

    typedef enum logic [2:0] {
        cmd_idle       = `VID_CMD_IDLE,
        cmd_write_data = `VID_CMD_WDATA,
        cmd_write_req  = `VID_CMD_WREQ
    } bus_cmd_t;

    typedef struct packed {
        logic                   en;     // Controller enable, ctrl[3]
        logic [`VID_PCNT_W-1:0] pcnt;   // Pixel divider, ctrl[9:4]
    } ctrl_reg_t;

    typedef struct packed {
        logic [`VID_CNT_W-1:0] hend;         // Last pixel of a line
        logic [`VID_CNT_W-1:0] hsize;        // Displayed pixels per line
        logic [`VID_CNT_W-1:0] hsync_start;
        logic [`VID_CNT_W-1:0] hsync_end;
        logic [`VID_CNT_W-1:0] vend;         // Last line of a frame
        logic [`VID_CNT_W-1:0] vsize;        // Displayed lines per frame
        logic [`VID_CNT_W-1:0] vsync_start;
        logic [`VID_CNT_W-1:0] vsync_end;
    } hv_regs_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        logic hsync;
        logic hblank;
        logic vsync;
        logic vblank;
        logic tick;         // Aligned with the updated sync and blank levels
        logic frame_start;
    } timing_t;

endpackage

// ==== design/vid_config.svh ====
`ifndef VID_CONFIG_SVH
`define VID_CONFIG_SVH

// Field and bus widths
`define VID_CNT_W        13
`define VID_PCNT_W       6
`define VID_ADDR_W       32
`define VID_FIFO_CNT_W   7

// Host bus command codes
`define VID_CMD_IDLE     3'b000
`define VID_CMD_WDATA    3'b001
`define VID_CMD_WREQ     3'b100

// Memory burst
`define VID_BURST_LEN    4
`define VID_LEN_CODE     2'b10

`define VID_FIFO_DEPTH   64

// Register byte offsets
`define VID_OFS_CTRL     32'h0000_0000
`define VID_OFS_H1       32'h0000_0028
`define VID_OFS_H2       32'h0000_0030
`define VID_OFS_V1       32'h0000_0038
`define VID_OFS_V2       32'h0000_0040
`define VID_OFS_BASE     32'h0000_0048
`define VID_OFS_LINEINC  32'h0000_0050

`endif
